/* logic/shader_front_pkg.sv */
package shader_front_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] pc_t;
	typedef logic [3:0] group_t;
	typedef logic [4:0] line_num_t;
	typedef logic [2:0] word_num_t;
	typedef logic [23:0] tag_t;
	typedef logic [28:0] line_addr_t; // {tag, line}
	typedef logic [255:0] line_data_t; // Word 0 in the low bits

	typedef enum logic [1:0] {
		CLASS_FPINT = 2'd0,
		CLASS_MEM   = 2'd1,
		CLASS_SFU   = 2'd2,
		CLASS_GROUP = 2'd3
	} op_class_e;

	typedef enum logic [2:0] {
		FPINT_MOV,
		FPINT_FMUL,
		FPINT_IMUL,
		FPINT_FADD,
		FPINT_FMAX,
		FPINT_FMIN,
		FPINT_FCVT
	} fpint_opcode_e;

	// setup_mul_float in bit 19 down to encode_enable in bit 1
	typedef logic [19:0] fpint_ctrl_t;
	localparam int CTRL_MINMAX_SWAP = 11;
	localparam int CTRL_WRITEBACK = 0;

	function automatic op_class_e insn_class(word_t insn);
		return op_class_e'(insn[31:30]);
	endfunction

	function automatic fpint_opcode_e insn_fpint_op(word_t insn);
		return fpint_opcode_e'(insn[29:27]);
	endfunction

	function automatic tag_t pc_tag(pc_t pc);
		return pc[31:8];
	endfunction

	function automatic line_num_t pc_line(pc_t pc);
		return pc[7:3];
	endfunction

	function automatic word_num_t pc_word(pc_t pc);
		return pc[2:0];
	endfunction

endpackage

/* logic/decode_fpint.sv */
`timescale 1ns/100ps

module decode_fpint import shader_front_pkg::*; (
	input  logic        clk,
	input  word_t       insn,
	input  logic        fpint_issue,
	output fpint_ctrl_t fpint_ctrl
);

	fpint_opcode_e opcode;
	logic [$bits(fpint_ctrl_t)-2:0] ctrl_row; // Everything above writeback

	assign opcode = insn_fpint_op(insn);

	// Issue is already registered upstream, so it lines up with the row
	always_comb begin
		fpint_ctrl = {ctrl_row, 1'b0};
		fpint_ctrl[CTRL_WRITEBACK] = fpint_issue;
	end

	// Fields are setup, mnorm, minmax, shiftr, addsub, clz, shiftl, round, encode
	always_ff @(posedge clk) begin
		case (opcode)
			FPINT_MOV:  ctrl_row <= 19'b01_01011_1001_0_01_1_1_11_1;
			FPINT_FMUL: ctrl_row <= 19'b10_00101_1001_0_01_1_1_11_1;
			FPINT_IMUL: ctrl_row <= 19'b00_01011_1001_0_01_1_1_10_0;
			FPINT_FADD: ctrl_row <= 19'b01_01000_1000_0_00_0_0_01_1;
			FPINT_FMAX, FPINT_FMIN: begin
				ctrl_row <= 19'b01_01000_0011_0_01_1_1_10_0;
				ctrl_row[CTRL_MINMAX_SWAP - 1] <= opcode == FPINT_FMIN;
			end
			FPINT_FCVT: ctrl_row <= 19'b01_01011_1000_1_11_0_0_01_1;
			default:    ctrl_row <= '0; // Opcode 7
		endcase
	end

endmodule

/* logic/decode_class.sv */
`timescale 1ns/100ps

module decode_class import shader_front_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  insn_valid,
	input  logic  insn_retry,
	input  word_t insn,
	output logic  disp_valid,
	output logic  disp_mem,
	output logic  disp_sfu,
	output logic  disp_group,
	output logic  fpint_issue
);

	logic [3:0] class_hot;
	logic issue;

	assign issue = insn_valid & ~insn_retry;

	always_comb begin
		class_hot = '0;
		class_hot[insn_class(insn)] = 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			disp_valid <= 1'b0;
			disp_mem <= 1'b0;
			disp_sfu <= 1'b0;
			disp_group <= 1'b0;
			fpint_issue <= 1'b0;
		end else begin
			disp_valid <= insn_valid; // Retried waves too
			disp_mem <= issue & class_hot[CLASS_MEM];
			disp_sfu <= issue & class_hot[CLASS_SFU];
			disp_group <= issue & class_hot[CLASS_GROUP];

			// FPINT port has no ready, so this is its writeback
			fpint_issue <= issue & class_hot[CLASS_FPINT];
		end
	end

endmodule

/* logic/icache_refill.sv */
`timescale 1ns/100ps

module icache_refill import shader_front_pkg::*; #(
	parameter int PENDING_DEPTH = 8
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       miss,
	input  line_addr_t miss_line,
	output logic       miss_taken,
	output logic       mem_req_valid,
	input  logic       mem_req_ready,
	output line_addr_t mem_req_line,
	input  logic       mem_beat_valid,
	output logic       mem_beat_ready,
	input  word_t      mem_beat_data,
	input  logic       mem_beat_last,
	output logic       fill_valid,
	output line_addr_t fill_line,
	output line_data_t fill_data
);

	localparam int PTR_W = $clog2(PENDING_DEPTH);
	localparam int CNT_W = $clog2(PENDING_DEPTH + 1);

	line_addr_t pending [PENDING_DEPTH];
	logic [PTR_W-1:0] wr_ptr, req_ptr, rd_ptr;
	logic [CNT_W-1:0] count; // Lines not yet filled
	logic [CNT_W-1:0] unreq; // Lines not yet requested
	logic req_fire, beat_fire;

	assign miss_taken = miss && count != CNT_W'(PENDING_DEPTH);

	assign mem_req_valid = unreq != '0;
	assign mem_req_line = pending[req_ptr];
	assign req_fire = mem_req_valid & mem_req_ready;

	assign mem_beat_ready = ~fill_valid; // Stall while the line goes out
	assign beat_fire = mem_beat_valid & mem_beat_ready;

	assign fill_line = pending[rd_ptr];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			req_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			unreq <= '0;
			fill_valid <= 1'b0;
		end else begin
			if (miss_taken)
				wr_ptr <= wr_ptr + 1'b1;
			if (req_fire)
				req_ptr <= req_ptr + 1'b1;
			if (fill_valid)
				rd_ptr <= rd_ptr + 1'b1;

			count <= count + CNT_W'(miss_taken) - CNT_W'(fill_valid);
			unreq <= unreq + CNT_W'(miss_taken) - CNT_W'(req_fire);
			fill_valid <= beat_fire & mem_beat_last;
		end
	end

	always_ff @(posedge clk) begin
		if (miss_taken)
			pending[wr_ptr] <= miss_line;

		// First beat ends up in word 0
		if (beat_fire)
			fill_data <= {mem_beat_data, fill_data[$bits(line_data_t)-1:$bits(word_t)]};
	end

	// Memory only returns lines that were requested and not yet filled
	assert property (@(posedge clk) disable iff (!rst_n) beat_fire |-> count != unreq);

endmodule

/* logic/icache_lookup.sv */
`timescale 1ns/100ps

module icache_lookup import shader_front_pkg::*; #(
	parameter int LINES = 32
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       icache_flush,
	input  logic       wave_valid,
	input  group_t     wave_group,
	input  pc_t        wave_pc,
	input  logic       fill_valid,
	input  line_addr_t fill_line,
	input  line_data_t fill_data,
	output logic       miss,
	output line_addr_t miss_line,
	input  logic       miss_taken,
	output logic       insn_valid,
	output logic       insn_retry,
	output group_t     insn_group,
	output word_t      insn
);

	typedef enum logic {
		FLUSH,
		RUN
	} state_e;

	state_e state;
	line_num_t flush_ptr;
	logic in_flush;

	logic [LINES-1:0] line_valid;
	logic [LINES-1:0] line_accessed;
	tag_t line_tag [LINES];
	line_data_t line_data [LINES];

	logic valid_1, valid_2, valid_3;
	logic flush_1, flush_2;
	pc_t pc_1, pc_2, pc_3;
	group_t group_1, group_2, group_3;
	word_num_t word_2, word_3;

	logic rd_valid;
	tag_t rd_tag;
	line_data_t rd_data;
	logic hit_3;
	logic [127:0] half_3;

	assign in_flush = state == FLUSH;
	assign word_2 = pc_word(pc_2);
	assign word_3 = pc_word(pc_3);

	// Only the first wave to find a line idle asks for it
	assign miss = valid_3 & ~hit_3 & ~line_accessed[pc_line(pc_3)] & ~in_flush;
	assign miss_line = {pc_tag(pc_3), pc_line(pc_3)};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= FLUSH;
			flush_ptr <= '0;
		end else begin
			case (state)
				FLUSH: begin
					flush_ptr <= flush_ptr + 1'b1;
					if (icache_flush)
						flush_ptr <= '0; // Hold at the start while requested
					else if (flush_ptr == line_num_t'(LINES - 1))
						state <= RUN;
				end
				RUN: begin
					if (icache_flush) begin
						state <= FLUSH;
						flush_ptr <= '0;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			line_valid <= '0;
			line_accessed <= '0;
		end else if (in_flush) begin
			line_valid[flush_ptr] <= 1'b0;
			line_accessed[flush_ptr] <= 1'b0;
		end else begin
			if (miss && miss_taken)
				line_accessed[pc_line(pc_3)] <= 1'b1;
			if (fill_valid) begin // Refill wins
				line_valid[line_num_t'(fill_line)] <= 1'b1;
				line_accessed[line_num_t'(fill_line)] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fill_valid && !in_flush) begin
			line_tag[line_num_t'(fill_line)] <= fill_line[$bits(line_addr_t)-1 -: $bits(tag_t)];
			line_data[line_num_t'(fill_line)] <= fill_data;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_1 <= 1'b0;
			valid_2 <= 1'b0;
			valid_3 <= 1'b0;
			insn_valid <= 1'b0;
		end else begin
			valid_1 <= wave_valid;
			valid_2 <= valid_1;
			valid_3 <= valid_2;
			insn_valid <= valid_3;
		end
	end

	always_ff @(posedge clk) begin
		pc_1 <= wave_pc;
		group_1 <= wave_group;
		flush_1 <= in_flush;

		rd_valid <= line_valid[pc_line(pc_1)];
		rd_tag <= line_tag[pc_line(pc_1)];
		rd_data <= line_data[pc_line(pc_1)];
		pc_2 <= pc_1;
		group_2 <= group_1;
		flush_2 <= flush_1;

		hit_3 <= rd_valid && rd_tag == pc_tag(pc_2) && !flush_2;
		half_3 <= word_2[2] ? rd_data[255:128] : rd_data[127:0];
		pc_3 <= pc_2;
		group_3 <= group_2;

		insn <= half_3[word_3[1:0] * 32 +: 32];
		insn_retry <= ~hit_3;
		insn_group <= group_3;
	end

	assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(insn_valid));

	// A missing wave must carry a known pc
	assert property (@(posedge clk) disable iff (!rst_n) miss |-> !$isunknown(miss_line));

endmodule

/* logic/shader_front.sv */
`timescale 1ns/100ps

module shader_front import shader_front_pkg::*; #(
	parameter int LINES = 32,
	parameter int PENDING_DEPTH = 8
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        wave_valid,
	input  group_t      wave_group,
	input  pc_t         wave_pc,
	input  logic        icache_flush,
	output logic        mem_req_valid,
	input  logic        mem_req_ready,
	output line_addr_t  mem_req_line,
	input  logic        mem_beat_valid,
	output logic        mem_beat_ready,
	input  word_t       mem_beat_data,
	input  logic        mem_beat_last,
	output logic        insn_valid,
	output logic        insn_retry,
	output group_t      insn_group,
	output word_t       insn,
	output logic        disp_valid,
	output logic        disp_mem,
	output logic        disp_sfu,
	output logic        disp_group,
	output logic        fpint_issue,
	output fpint_ctrl_t fpint_ctrl
);

	logic miss, miss_taken, fill_valid;
	line_addr_t miss_line, fill_line;
	line_data_t fill_data;

	icache_lookup #(.LINES(LINES)) u_icache_lookup (
		.clk,
		.rst_n,
		.icache_flush,
		.wave_valid,
		.wave_group,
		.wave_pc,
		.fill_valid,
		.fill_line,
		.fill_data,
		.miss,
		.miss_line,
		.miss_taken,
		.insn_valid,
		.insn_retry,
		.insn_group,
		.insn
	);

	icache_refill #(.PENDING_DEPTH(PENDING_DEPTH)) u_icache_refill (
		.clk,
		.rst_n,
		.miss,
		.miss_line,
		.miss_taken,
		.mem_req_valid,
		.mem_req_ready,
		.mem_req_line,
		.mem_beat_valid,
		.mem_beat_ready,
		.mem_beat_data,
		.mem_beat_last,
		.fill_valid,
		.fill_line,
		.fill_data
	);

	decode_class u_decode_class (
		.clk,
		.rst_n,
		.insn_valid,
		.insn_retry,
		.insn,
		.disp_valid,
		.disp_mem,
		.disp_sfu,
		.disp_group,
		.fpint_issue
	);

	decode_fpint u_decode_fpint (
		.clk,
		.insn,
		.fpint_issue,
		.fpint_ctrl
	);

endmodule

/* bench/shader_front_tb.sv */
`timescale 1ns/100ps

module shader_front_tb import shader_front_pkg::*; ();

	localparam int LINES = 32;
	localparam int PENDING_DEPTH = 8;
	localparam int NUM_REC = 18;
	localparam int FLUSH_REC = 4; // Cached before the midway flush
	localparam int IDLE_CYCLES = LINES + 8;
	localparam int TIMEOUT = NUM_REC * 200 + 2 * LINES;

	logic clk;
	logic rst_n;
	logic wave_valid;
	group_t wave_group;
	pc_t wave_pc;
	logic icache_flush;
	logic mem_req_valid;
	logic mem_req_ready = 1'b0;
	line_addr_t mem_req_line;
	logic mem_beat_valid = 1'b0;
	logic mem_beat_ready;
	word_t mem_beat_data = '0;
	logic mem_beat_last = 1'b0;
	logic insn_valid, insn_retry;
	group_t insn_group;
	word_t insn;
	logic disp_valid, disp_mem, disp_sfu, disp_group, fpint_issue;
	fpint_ctrl_t fpint_ctrl;

	logic [31:0] pat [0:NUM_REC*5-1]; // group, pc, insn, class, ctrl
	line_addr_t req_q [$];
	int beat_idx = 0;
	logic beat_held;
	logic line_done = 1'b0; // Last beat of a line went through
	logic [31:0] rng = 32'h5d0d;
	int cycles = 0;
	int checks = 0;
	int errors = 0;

	shader_front #(
		.LINES(LINES),
		.PENDING_DEPTH(PENDING_DEPTH)
	) u_shader_front (
		.clk, .rst_n,
		.wave_valid, .wave_group, .wave_pc, .icache_flush,
		.mem_req_valid, .mem_req_ready, .mem_req_line,
		.mem_beat_valid, .mem_beat_ready, .mem_beat_data, .mem_beat_last,
		.insn_valid, .insn_retry, .insn_group, .insn,
		.disp_valid, .disp_mem, .disp_sfu, .disp_group,
		.fpint_issue, .fpint_ctrl
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] seed);
		return seed * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] mem_word(input logic [31:0] pc);
		logic [31:0] w;
		int i;
		w = pc & 32'h07ff_ffff;
		for (i = 0; i < NUM_REC; i++)
			if (pat[i*5+1] == pc)
				w = pat[i*5+2];
		return w;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0d ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	// In-order memory, one line per request, 8 beats with random gaps
	always @(posedge clk) begin
		if (!rst_n) begin
			req_q.delete();
			beat_idx = 0;
			line_done = 1'b0;
			mem_req_ready <= 1'b0;
			mem_beat_valid <= 1'b0;
			mem_beat_last <= 1'b0;
		end else begin
			rng = lcg_next(rng);
			beat_held = mem_beat_valid & ~mem_beat_ready;
			// Beats stall only while the finished line is handed over
			check_value("mem_beat_ready", 32'(mem_beat_ready), 32'(!line_done));
			line_done = mem_beat_valid & mem_beat_ready & mem_beat_last;
			if (mem_req_valid && mem_req_ready)
				req_q.push_back(mem_req_line);
			if (mem_beat_valid && mem_beat_ready) begin
				if (beat_idx == 7) begin
					beat_idx = 0;
					void'(req_q.pop_front());
				end else begin
					beat_idx = beat_idx + 1;
				end
			end
			mem_req_ready <= rng[30:28] != 3'd0; // Refuses about one cycle in eight
			if (!beat_held) begin
				if (req_q.size() != 0 && rng[26:25] != 2'd0) begin
					mem_beat_valid <= 1'b1;
					mem_beat_data <= mem_word({req_q[0], 3'(beat_idx)});
					mem_beat_last <= beat_idx == 7;
				end else begin
					mem_beat_valid <= 1'b0;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("Timeout: a wave never completed within %0d cycles", TIMEOUT);
			$display("Checks: %0d, errors: %0d", checks, errors);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	task automatic send_wave(input int rec);
		@(posedge clk);
		wave_valid <= 1'b1;
		wave_group <= pat[rec*5][3:0];
		wave_pc <= pat[rec*5+1];
		@(posedge clk);
		wave_valid <= 1'b0;
	endtask

	// Waits for the lookup result, then checks the dispatch cycle after it
	task automatic collect(input int rec, output logic completed);
		logic [1:0] cls;
		cls = pat[rec*5+3][1:0];
		@(posedge clk);
		while (insn_valid !== 1'b1)
			@(posedge clk);
		completed = ~insn_retry;
		if (completed) begin
			check_value("insn", insn, pat[rec*5+2]);
			check_value("insn_group", 32'(insn_group), 32'(pat[rec*5][3:0]));
		end
		@(posedge clk);
		check_value("disp_valid", 32'(disp_valid), 32'd1);
		if (completed) begin
			check_value("dispatch strobes", 32'({disp_group, disp_sfu, disp_mem, fpint_issue}),
				32'(4'b0001 << cls));
			if (cls == CLASS_FPINT)
				check_value("fpint_ctrl", 32'(fpint_ctrl), 32'(pat[rec*5+4][19:0]));
		end else begin
			check_value("dispatch strobes", 32'({disp_group, disp_sfu, disp_mem, fpint_issue}),
				32'd0);
		end
	endtask

	task automatic run_record(input int rec);
		logic completed;
		completed = 1'b0;
		while (!completed) begin
			send_wave(rec);
			collect(rec, completed);
		end
	endtask

	task automatic flush_recheck(input int rec);
		logic completed;
		@(posedge clk);
		icache_flush <= 1'b1;
		@(posedge clk);
		icache_flush <= 1'b0;
		send_wave(rec); // Lands while the flush walk runs
		collect(rec, completed);
		check_value("insn_retry", 32'(!completed), 32'd1);
		run_record(rec);
	endtask

	initial begin
		int rec;
		rst_n = 1'b0;
		wave_valid = 1'b0;
		wave_group = '0;
		wave_pc = '0;
		icache_flush = 1'b0;
		$readmemh("bench/shader_front_patterns.hex", pat);
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;

		// Quiet outputs through the startup flush
		repeat (IDLE_CYCLES) begin
			@(posedge clk);
			check_value("disp_valid", 32'(disp_valid), 32'd0);
			check_value("mem_req_valid", 32'(mem_req_valid), 32'd0);
		end

		for (rec = 0; rec < NUM_REC; rec++) begin
			if (rec == NUM_REC / 2)
				flush_recheck(FLUSH_REC);
			run_record(rec);
		end

		repeat (2) @(posedge clk);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* files.f */
logic/shader_front_pkg.sv
logic/decode_fpint.sv
logic/decode_class.sv
logic/icache_refill.sv
logic/icache_lookup.sv
logic/shader_front.sv
bench/shader_front_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the shader front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f files.f --top-module shader_front_tb -Mdir obj_dir -o shader_front_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/shader_front_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "TESTBENCH PASSED"; then
	exit 0
fi
exit 1

/* bench/shader_front_patterns.hex */
// group pc insn class fpint_ctrl, one wave per line
// pcs not listed here read back as the pc with bits 31..27 cleared
1 00000010 00001234 0 5727F
2 00000011 08000abc 0 8B27F
3 00000012 10000055 0 17279
4 00000017 18000777 0 51007
5 00000020 20000001 0 50679
6 00000021 28000002 0 50E79
7 00000022 30000003 0 571C7
8 00000023 38000004 0 00001
9 00001010 40000abc 1 00000
a 00001013 80001111 2 00000
b 000000f8 c0000042 3 00000
c 00000010 00001234 0 5727F
d 12345678 5abcdef0 1 00000
e 00abcdef 9fffffff 2 00000
f fffffff8 e0000000 3 00000
0 00000016 18000000 0 51007
1 0000ffff 2fffffff 0 50E79
2 00000011 08000abc 0 8B27F
